/* filelist.f */
source/flash_pkg.sv
source/flash_read_if.sv
source/axi_flash_request.sv
source/qspi_flash_reader.sv
source/read_word_assembler.sv
source/axi4lite_flash_top.sv
tests/qspi_flash_model.sv
tests/tb_axi4lite_flash_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_axi4lite_flash_top -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* tests/tb_axi4lite_flash_top.sv */
`default_nettype none

module tb_axi4lite_flash_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FLASH_ADDR_BITS = 24;
    localparam int RANDOM_READS    = 30;
    localparam int STALL_READS     = 6;
    // Address zero, random, stalled, wrap and the read after the write
    localparam int TOTAL_READS     = 1 + RANDOM_READS + STALL_READS + 2;
    localparam int CYCLE_LIMIT     = 40 * 200 + 1000;

    logic                                  bus = 1'b0;
    logic                                  rst;
    logic                                  arvalid;
    logic [FLASH_ADDR_BITS-1:0]            araddr;
    logic                                  arready;
    logic                                  rvalid;
    logic                                  rready;
    flash_pkg::read_word_t                 rdata;
    flash_pkg::axi_resp_e                  rresp;
    logic                                  awvalid;
    logic [FLASH_ADDR_BITS-1:0]            awaddr;
    logic                                  awready;
    logic                                  wvalid;
    flash_pkg::read_word_t                 wdata;
    logic [flash_pkg::READ_WORD_BYTES-1:0] wstrb;
    logic                                  wready;
    logic                                  bvalid;
    logic                                  bready;
    flash_pkg::axi_resp_e                  bresp;
    logic                                  cs;
    logic                                  sclk;
    logic [3:0]                            io_out;
    logic [3:0]                            io_oe;
    logic [3:0]                            io_line;
    logic [3:0]                            model_drive;
    logic [3:0]                            model_oe;

    logic [FLASH_ADDR_BITS-1:0] pending_addr[$];
    logic [FLASH_ADDR_BITS-1:0] done_addr;
    int                         reads_done = 0;
    int                         writes_done = 0;
    int                         cycles = 0;

    always #2 bus = ~bus;

    axi4lite_flash_top #(.FLASH_ADDR_BITS(FLASH_ADDR_BITS)) dut_i (
        .io_in (io_line),
        .*
    );

    qspi_flash_model #(.FLASH_ADDR_BITS(FLASH_ADDR_BITS)) flash_i (
        .cs       (cs),
        .sclk     (sclk),
        .io       (io_line),
        .drive    (model_drive),
        .drive_oe (model_oe)
    );

    // IO lines are pulled up and the DUT's enable wins over the flash
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (io_oe[i] === 1'b1) begin
                io_line[i] = io_out[i];
            end else if (model_oe[i] === 1'b1) begin
                io_line[i] = model_drive[i];
            end else begin
                io_line[i] = 1'b1;
            end
        end
    end

    function automatic flash_pkg::flash_byte_t flash_byte(input logic [23:0] a);
        logic [23:0] prod;
        prod = a * 24'd37;
        return prod[7:0] ^ a[15:8] ^ a[23:16];
    endfunction

    // Byte i of the word comes from addr + i, wrapping at the flash size
    function automatic flash_pkg::read_word_t expected_word(input logic [FLASH_ADDR_BITS-1:0] addr);
        flash_pkg::read_word_t      word;
        logic [FLASH_ADDR_BITS-1:0] a;
        word = '0;
        for (int i = 0; i < flash_pkg::READ_WORD_BYTES; i++) begin
            a = addr + FLASH_ADDR_BITS'(i);
            word[8*i +: 8] = flash_byte(24'(a));
        end
        return word;
    endfunction

    task automatic check_word(input flash_pkg::read_word_t got, input flash_pkg::read_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_resp(input flash_pkg::axi_resp_e got, input flash_pkg::axi_resp_e exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Outputs are read and inputs driven 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge bus);
        #1;
    endtask

    task automatic axi_read(input logic [FLASH_ADDR_BITS-1:0] addr, input bit stall,
                            input int hold);
        flash_pkg::read_word_t held;
        logic                  accepted;
        accepted = 1'b0;
        araddr   = addr;
        arvalid  = 1'b1;
        rready   = !stall;
        while (!accepted) begin
            accepted = arready;
            if (accepted) begin
                pending_addr.push_back(addr);
            end
            next_cycle();
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            check_flag(arready, 1'b0, "arready while a read is outstanding");
            next_cycle();
        end
        if (stall) begin
            held = rdata;
            repeat (hold) begin
                next_cycle();
                check_flag(rvalid, 1'b1, "rvalid under back-pressure");
                check_flag(arready, 1'b0, "arready under back-pressure");
                check_word(rdata, held, "rdata under back-pressure");
            end
            rready = 1'b1;
        end
        next_cycle();
        check_flag(rvalid, 1'b0, "rvalid after the R handshake");
        check_flag(arready, 1'b1, "arready after the R handshake");
    endtask

    // Writes the complement of the stored word, which must never reach the flash
    task automatic axi_write(input logic [FLASH_ADDR_BITS-1:0] addr, input int hold);
        awaddr  = addr;
        wdata   = ~expected_word(addr);
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        while (!awready) begin
            check_flag(wready, 1'b0, "wready before awready");
            next_cycle();
        end
        check_flag(wready, 1'b1, "wready together with awready");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_flag(bvalid, 1'b1, "bvalid the cycle after the write");
        check_flag(awready, 1'b0, "awready after its pulse");
        check_flag(wready, 1'b0, "wready after its pulse");
        repeat (hold) begin
            next_cycle();
            check_flag(bvalid, 1'b1, "bvalid waiting for bready");
        end
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
        check_flag(bvalid, 1'b0, "bvalid after the B handshake");
    endtask

    // Every R and B handshake is compared with the reference
    always @(posedge bus) begin
        if (!rst && rvalid && rready) begin
            if (pending_addr.size() == 0) begin
                $display("Read response at %0t with no read outstanding", $time);
                $display("test failed");
                $fatal(1, "unexpected read response");
            end else begin
                done_addr = pending_addr.pop_front();
                check_word(rdata, expected_word(done_addr), "rdata");
                check_resp(rresp, flash_pkg::AXI_RESP_OKAY, "rresp");
                reads_done++;
            end
        end
        if (!rst && bvalid && bready) begin
            check_resp(bresp, flash_pkg::AXI_RESP_SLVERR, "bresp");
            writes_done++;
        end
    end

    always @(posedge bus) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, the DUT stopped responding after %0d cycles", cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [FLASH_ADDR_BITS-1:0] addr;
        int                         hold;
        rst     = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        void'($urandom(54231));
        repeat (5) @(posedge bus);
        #1;
        rst = 1'b0;

        check_flag(arready, 1'b1, "arready after reset");
        check_flag(rvalid, 1'b0, "rvalid after reset");
        check_flag(bvalid, 1'b0, "bvalid after reset");
        check_flag(awready, 1'b0, "awready after reset");
        check_flag(wready, 1'b0, "wready after reset");
        check_flag(cs, 1'b1, "cs after reset");
        check_flag(sclk, 1'b0, "sclk after reset");
        check_flag(|io_oe, 1'b0, "io_oe after reset");

        axi_read('0, 1'b0, 0);
        repeat (RANDOM_READS) begin
            addr = FLASH_ADDR_BITS'($urandom());
            axi_read(addr, 1'b0, 0);
        end
        repeat (STALL_READS) begin
            addr = FLASH_ADDR_BITS'($urandom());
            hold = int'($urandom() % 21);
            axi_read(addr, 1'b1, hold);
        end

        // Last three bytes of the flash, then addresses 0 to 4
        axi_read(FLASH_ADDR_BITS'((1 << FLASH_ADDR_BITS) - 3), 1'b0, 0);

        addr = FLASH_ADDR_BITS'($urandom());
        hold = int'($urandom() % 8);
        axi_write(addr, hold);
        axi_read(addr, 1'b0, 0);

        repeat (2) next_cycle();
        if (reads_done == TOTAL_READS && writes_done == 1 && pending_addr.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Responses missing, %0d of %0d reads and %0d of 1 writes seen",
                     reads_done, TOTAL_READS, writes_done);
            $display("test failed");
            $fatal(1, "missing responses");
        end
    end

endmodule

`default_nettype wire

/* tests/qspi_flash_model.sv */
`default_nettype none

module qspi_flash_model #(
    parameter int FLASH_ADDR_BITS = 24
) (
    input  logic       cs,
    input  logic       sclk,
    input  logic [3:0] io,
    output logic [3:0] drive,
    output logic [3:0] drive_oe
);

    timeunit 1ns;
    timeprecision 100ps;

    // Rising SCLK edges before the first data nibble
    localparam int CMD_EDGES    = 8;
    localparam int ADDR_EDGES   = 24;
    localparam int HEADER_EDGES = CMD_EDGES + ADDR_EDGES + flash_pkg::FLASH_DUMMY_CLOCKS;

    int                         rises = 0;
    int                         nib;
    logic [7:0]                 opcode;
    logic [23:0]                start_addr;
    logic [FLASH_ADDR_BITS-1:0] cur_addr;
    flash_pkg::flash_byte_t     cur_byte;

    // Content of the simulated array
    function automatic flash_pkg::flash_byte_t stored_byte(input logic [23:0] a);
        logic [23:0] prod;
        prod = a * 24'd37;
        return prod[7:0] ^ a[15:8] ^ a[23:16];
    endfunction

    // Opcode and address bits are taken from IO0 on rising SCLK
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            rises <= 0;
        end else begin
            if (rises < CMD_EDGES) begin
                opcode <= {opcode[6:0], io[0]};
            end else if (rises < CMD_EDGES + ADDR_EDGES) begin
                start_addr <= {start_addr[22:0], io[0]};
            end
            rises <= rises + 1;
        end
    end

    // Nibbles change on falling SCLK, high nibble of each byte first
    // Unknown opcodes leave the lines to the pull-up
    always @(negedge sclk or posedge cs) begin
        if (cs) begin
            drive_oe <= 4'b0000;
        end else if (rises >= HEADER_EDGES && opcode == flash_pkg::FLASH_CMD_QUAD_READ) begin
            nib      = rises - HEADER_EDGES;
            cur_addr = FLASH_ADDR_BITS'(start_addr + 24'(nib / 2));
            cur_byte = stored_byte(24'(cur_addr));
            drive    <= nib[0] ? cur_byte[3:0] : cur_byte[7:4];
            drive_oe <= 4'b1111;
        end
    end

endmodule

`default_nettype wire

/* source/axi4lite_flash_top.sv */
`default_nettype none

module axi4lite_flash_top #(
    parameter int FLASH_ADDR_BITS = 24
) (
    input  logic                                  bus,
    input  logic                                  rst,

    // AXI4-Lite read channels
    input  logic                                  arvalid,
    input  logic [FLASH_ADDR_BITS-1:0]            araddr,
    output logic                                  arready,
    output logic                                  rvalid,
    input  logic                                  rready,
    output flash_pkg::read_word_t                 rdata,
    output flash_pkg::axi_resp_e                  rresp,

    // AXI4-Lite write channels, always refused
    input  logic                                  awvalid,
    input  logic [FLASH_ADDR_BITS-1:0]            awaddr,
    output logic                                  awready,
    input  logic                                  wvalid,
    input  flash_pkg::read_word_t                 wdata,
    input  logic [flash_pkg::READ_WORD_BYTES-1:0] wstrb,
    output logic                                  wready,
    output logic                                  bvalid,
    input  logic                                  bready,
    output flash_pkg::axi_resp_e                  bresp,

    // QSPI flash pins
    input  logic [3:0]                            io_in,
    output logic                                  cs,
    output logic                                  sclk,
    output logic [3:0]                            io_out,
    output logic [3:0]                            io_oe
);

    logic last_byte;

    flash_read_if #(.FLASH_ADDR_BITS(FLASH_ADDR_BITS)) rd_if ();

    // awaddr, wdata and wstrb are part of the bus but every write is refused
    axi_flash_request #(.FLASH_ADDR_BITS(FLASH_ADDR_BITS)) u_request (
        .bus       (bus),
        .rst       (rst),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .bready    (bready),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .last_byte (last_byte),
        .req       (rd_if.requester)
    );

    qspi_flash_reader #(.FLASH_ADDR_BITS(FLASH_ADDR_BITS)) u_reader (
        .bus    (bus),
        .rst    (rst),
        .io_in  (io_in),
        .cs     (cs),
        .sclk   (sclk),
        .io_out (io_out),
        .io_oe  (io_oe),
        .req    (rd_if.reader)
    );

    read_word_assembler u_assembler (
        .bus       (bus),
        .rst       (rst),
        .last_byte (last_byte),
        .rready    (rready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .bytes     (rd_if.sink)
    );

endmodule

`default_nettype wire

/* source/read_word_assembler.sv */
`default_nettype none

module read_word_assembler (
    input  logic                 bus,
    input  logic                 rst,
    input  logic                 last_byte,
    input  logic                 rready,
    output logic                 rvalid,
    output flash_pkg::read_word_t rdata,
    output flash_pkg::axi_resp_e rresp,

    flash_read_if.sink           bytes
);

    localparam int WORD_BITS = $bits(flash_pkg::read_word_t);
    localparam int BYTE_BITS = $bits(flash_pkg::flash_byte_t);

    flash_pkg::read_word_t word_q;

    // New bytes enter at the top, so after eight of them
    // the first byte sits in the lowest lane
    always_ff @(posedge bus) begin
        if (bytes.byte_ready) begin
            word_q <= {bytes.byte_data, word_q[WORD_BITS-1:BYTE_BITS]};
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end else if (bytes.byte_ready && last_byte) begin
            rvalid <= 1'b1;
        end
    end

    // No bytes arrive while rvalid waits, so rdata holds under back-pressure
    assign rdata = word_q;
    assign rresp = flash_pkg::AXI_RESP_OKAY;

endmodule

`default_nettype wire

/* source/qspi_flash_reader.sv */
`default_nettype none

module qspi_flash_reader #(
    parameter int FLASH_ADDR_BITS = 24
) (
    input  logic        bus,
    input  logic        rst,

    // Flash pins, split into out, enable and in for each IO line
    input  logic [3:0]  io_in,
    output logic        cs,
    output logic        sclk,
    output logic [3:0]  io_out,
    output logic [3:0]  io_oe,

    flash_read_if.reader req
);

    localparam int CMD_BITS  = 8;
    localparam int WIRE_BITS = 24;

    flash_pkg::reader_state_e      state;
    logic [4:0]                    cnt;
    logic [CMD_BITS+WIRE_BITS-1:0] shreg;
    logic [WIRE_BITS-1:0]          addr_wide;
    logic                          can_start;
    logic                          pending;
    logic                          hi_done;
    logic [3:0]                    nibble_hi;
    flash_pkg::flash_byte_t        byte_q;
    logic                          byte_ready_q;

    // Flash addresses are always 24 bits on the wire
    assign addr_wide = WIRE_BITS'(req.addr);

    // GAP counts as idle, a new request is held until CS has been high long enough
    assign can_start = state == flash_pkg::IDLE || state == flash_pkg::GAP;

    always_ff @(posedge bus) begin
        if (rst) begin
            state        <= flash_pkg::IDLE;
            cs           <= 1'b1;
            sclk         <= 1'b0;
            cnt          <= 5'd0;
            pending      <= 1'b0;
            hi_done      <= 1'b0;
            byte_ready_q <= 1'b0;
        end else begin
            byte_ready_q <= 1'b0;
            case (state)
                flash_pkg::IDLE: begin
                    if (req.start) begin
                        state <= flash_pkg::CMD;
                        cs    <= 1'b0;
                        cnt   <= 5'(CMD_BITS - 1);
                    end
                end
                flash_pkg::CMD: begin
                    sclk <= ~sclk;
                    // Bits advance on the falling edge
                    if (sclk) begin
                        if (cnt == 5'd0) begin
                            state <= flash_pkg::ADDR;
                            cnt   <= 5'(WIRE_BITS - 1);
                        end else begin
                            cnt <= cnt - 5'd1;
                        end
                    end
                end
                flash_pkg::ADDR: begin
                    sclk <= ~sclk;
                    if (sclk) begin
                        if (cnt == 5'd0) begin
                            state <= flash_pkg::DUMMY;
                            cnt   <= 5'(flash_pkg::FLASH_DUMMY_CLOCKS - 1);
                        end else begin
                            cnt <= cnt - 5'd1;
                        end
                    end
                end
                flash_pkg::DUMMY: begin
                    sclk <= ~sclk;
                    if (sclk) begin
                        if (cnt == 5'd0) begin
                            state   <= flash_pkg::DATA;
                            hi_done <= 1'b0;
                        end else begin
                            cnt <= cnt - 5'd1;
                        end
                    end
                end
                flash_pkg::DATA: begin
                    if (!sclk) begin
                        // keep is checked before the high nibble of the next byte
                        if (!hi_done && !req.keep) begin
                            state <= flash_pkg::GAP;
                            cs    <= 1'b1;
                            cnt   <= 5'd1;
                        end else begin
                            sclk         <= 1'b1;
                            hi_done      <= ~hi_done;
                            byte_ready_q <= hi_done;
                        end
                    end else begin
                        sclk <= 1'b0;
                    end
                end
                flash_pkg::GAP: begin
                    if (cnt == 5'd0) begin
                        if (pending || req.start) begin
                            state   <= flash_pkg::CMD;
                            cs      <= 1'b0;
                            cnt     <= 5'(CMD_BITS - 1);
                            pending <= 1'b0;
                        end else begin
                            state <= flash_pkg::IDLE;
                        end
                    end else begin
                        cnt <= cnt - 5'd1;
                        if (req.start) begin
                            pending <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= flash_pkg::IDLE;
                    cs    <= 1'b1;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    // Opcode then address, MSB first
    always_ff @(posedge bus) begin
        if (req.start && can_start) begin
            shreg <= {flash_pkg::FLASH_CMD_QUAD_READ, addr_wide};
        end else if ((state == flash_pkg::CMD || state == flash_pkg::ADDR) && sclk) begin
            shreg <= {shreg[CMD_BITS+WIRE_BITS-2:0], 1'b0};
        end
    end

    // Sample on the edge that raises SCLK, high nibble first
    always_ff @(posedge bus) begin
        if (state == flash_pkg::DATA && !sclk) begin
            if (!hi_done) begin
                nibble_hi <= io_in;
            end else begin
                byte_q <= {nibble_hi, io_in};
            end
        end
    end

    assign io_out = {3'b000, shreg[CMD_BITS+WIRE_BITS-1]};
    assign io_oe  = (state == flash_pkg::CMD || state == flash_pkg::ADDR) ? 4'b0001 : 4'b0000;

    assign req.byte_ready = byte_ready_q;
    assign req.byte_data  = byte_q;

endmodule

`default_nettype wire

/* source/axi_flash_request.sv */
`default_nettype none

module axi_flash_request #(
    parameter int FLASH_ADDR_BITS = 24
) (
    input  logic                       bus,
    input  logic                       rst,

    // AXI read address channel
    input  logic [FLASH_ADDR_BITS-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,

    // R channel state, owned by the assembler
    input  logic                       rvalid,
    input  logic                       rready,

    // AXI write channels
    input  logic                       awvalid,
    input  logic                       wvalid,
    input  logic                       bready,
    output logic                       awready,
    output logic                       wready,
    output logic                       bvalid,
    output flash_pkg::axi_resp_e       bresp,

    output logic                       last_byte,

    flash_read_if.requester            req
);

    logic [3:0] remaining;
    logic       ar_fire;
    logic       wr_accept;

    assign ar_fire = arready && arvalid;

    // The flash read starts in the same cycle as the AR handshake
    assign req.start = ar_fire;
    assign req.addr  = araddr;
    assign req.keep  = remaining != 4'd0;

    // Counter still holds one while the eighth byte is on the interface
    assign last_byte = remaining == 4'd1;

    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b1;
        end else if (ar_fire) begin
            arready <= 1'b0;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            remaining <= 4'd0;
        end else if (ar_fire) begin
            remaining <= 4'(flash_pkg::READ_WORD_BYTES);
        end else if (req.byte_ready && remaining != 4'd0) begin
            remaining <= remaining - 4'd1;
        end
    end

    // Write error responder, unrelated to the read path
    // AW and W are taken together, one transfer at a time
    always_ff @(posedge bus) begin
        if (rst) begin
            wr_accept <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (wr_accept) begin
                bvalid <= 1'b1;
            end
        end
    end

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign bresp   = flash_pkg::AXI_RESP_SLVERR;

endmodule

`default_nettype wire

/* source/flash_read_if.sv */
`default_nettype none

interface flash_read_if #(
    parameter int FLASH_ADDR_BITS = 24
);

    // Request side
    logic                       start;
    logic                       keep;
    logic [FLASH_ADDR_BITS-1:0] addr;

    // Byte stream back from the flash
    logic                       byte_ready;
    flash_pkg::flash_byte_t     byte_data;

    modport requester (
        output start,
        output keep,
        output addr,
        input  byte_ready
    );

    modport reader (
        input  start,
        input  keep,
        input  addr,
        output byte_ready,
        output byte_data
    );

    // Observes the byte stream only
    modport sink (
        input byte_ready,
        input byte_data
    );

endinterface

`default_nettype wire

/* source/flash_pkg.sv */
`default_nettype none

package flash_pkg;

    // AXI response codes, only the two this slave ever returns
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'd0,
        AXI_RESP_SLVERR = 2'd2
    } axi_resp_e;

    // One AXI read word is eight consecutive flash bytes
    parameter int READ_WORD_BYTES = 8;

    typedef logic [8*READ_WORD_BYTES-1:0] read_word_t;

    typedef logic [7:0] flash_byte_t;

    // Fast Read Quad Output, serial command and address, quad data
    parameter logic [7:0] FLASH_CMD_QUAD_READ = 8'h6B;

    // SCLK periods between the last address bit and the first data nibble
    parameter int FLASH_DUMMY_CLOCKS = 8;

    // QSPI sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DUMMY,
        DATA,
        GAP
    } reader_state_e;

endpackage

`default_nettype wire
